//--- link_test.f
+incdir+include
rtl/link_test_pkg.sv
rtl/ccb_cmd_decoder.sv
rtl/link_boot_sequencer.sv
rtl/prbs_error_monitor.sv
rtl/link_test_top.sv
bench/link_test_tb.sv

//--- Makefile
# Verilator flow for the link test controller

VERILATOR ?= verilator
TOP       ?= link_test_tb
FILELIST  ?= link_test.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/link_test_tb.sv
`default_nettype none

`include "link_test_defines.svh"

module link_test_tb;

    import link_test_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 100;
    localparam int INJECT_CYCLES = 40;
    // Full boot plus every test phase plus slack for waits and commands
    localparam int RUN_CYCLES    = RESET_CYCLES + `TX_WAIT_CYCLES + `RX_WAIT_CYCLES
                                 + `CLEAR_END_CYCLES + 2 * RANDOM_CYCLES + INJECT_CYCLES + 50;
    localparam int WATCHDOG_TIME = 2 * RUN_CYCLES * CLK_PERIOD;

    logic        clk40 = 1'b0;
    logic        PRBS_reset;
    ccb_cmd_t    ccb_cmd_n;
    logic        ccb_strobe_n;
    logic        inject;
    lane_vec_t   tx_reset_done;
    lane_vec_t   rx_reset_done;
    lane_vec_t   prbs_error;
    lane_vec_t   tx_reset;
    lane_vec_t   rx_reset;
    logic        error_inject;
    logic        prbs_cnt_reset;
    led_t        led;
    boot_state_t state;

    // Command on the bus this cycle
    // Zero while the bus is idle
    ccb_cmd_t    sent_cmd;
    // Two-edge command latency through the decoder
    ccb_cmd_t    cmd_stage1;
    ccb_cmd_t    cmd_stage2;
    logic        resync_seen;
    logic        tx_done_seen;
    boot_state_t last_state;
    int          dwell;
    int          dwell_expected;
    lane_vec_t   latch_model;
    err_cnt_t    cnt_model [`ERR_CNT_LANES];
    logic        cnt_clear;
    logic        inject_exp;
    logic        cnt_reset_exp;
    lane_vec_t   tx_reset_exp;
    lane_vec_t   rx_reset_exp;
    led_t        led_exp;

    always #(CLK_PERIOD / 2) clk40 = ~clk40;

    link_test_top link_test_top_inst (
        .clk40            (clk40),
        .PRBS_reset       (PRBS_reset),
        .ccb_cmd_n_i      (ccb_cmd_n),
        .ccb_strobe_n_i   (ccb_strobe_n),
        .inject_i         (inject),
        .tx_reset_done_i  (tx_reset_done),
        .rx_reset_done_i  (rx_reset_done),
        .prbs_error_i     (prbs_error),
        .tx_reset_o       (tx_reset),
        .rx_reset_o       (rx_reset),
        .error_inject_o   (error_inject),
        .prbs_cnt_reset_o (prbs_cnt_reset),
        .led_o            (led),
        .state_o          (state)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cnt_clear     = (state != EN_PRBS_CK) || (cmd_stage2 == `CMD_BXRESET);
        cnt_reset_exp = (state == PRBS_INJECT_DONE)
                     || ((state == EN_PRBS_CK) && (cmd_stage2 == `CMD_BXRESET));
        tx_reset_exp  = (state == RESET) ? 8'hff : 8'h00;
        rx_reset_exp  = (state inside {RESET, EN_TX, EN_TX_DONE}) ? 8'hff : 8'h00;
        // Inject stays on through the injection steps
        // Pin or bx0 drives it while checking
        inject_exp = state inside {EN_RX_DONE, PRBS_INJECT, PRBS_INJECT_DONE};
        if (state == EN_PRBS_CK) begin
            inject_exp = inject || (cmd_stage2 == `CMD_BX0);
        end
        case (state)
            PRBS_INJECT:       led_exp = {4'h6, latch_model[7:4]};
            PRBS_INJECT_DONE:  led_exp = {4'h8, latch_model[7:4]};
            PRBS_INJECT_CLEAR: led_exp = {4'h7, latch_model[7:4]};
            EN_PRBS_CK: led_exp = {cnt_model[0], cnt_model[1], cnt_model[2], cnt_model[3]};
            // Boot states show code plus one on the top nibble
            default:           led_exp = {4'(state) + 4'd1, 4'h0};
        endcase
        // Cycles each timed step lasts
        // RESET always lasts a single cycle
        case (last_state)
            RESET:             dwell_expected = 1;
            EN_TX:             dwell_expected = `TX_WAIT_CYCLES + 1;
            EN_RX:             dwell_expected = `RX_WAIT_CYCLES + 1;
            PRBS_INJECT:       dwell_expected = `INJECT_END_CYCLES + 1;
            PRBS_INJECT_DONE:  dwell_expected = `RESET_END_CYCLES - `INJECT_END_CYCLES;
            PRBS_INJECT_CLEAR: dwell_expected = `CLEAR_END_CYCLES - `RESET_END_CYCLES;
            default:           dwell_expected = 0;
        endcase
    end

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            cmd_stage1   <= '0;
            cmd_stage2   <= '0;
            resync_seen  <= 1'b0;
            tx_done_seen <= 1'b0;
            last_state   <= RESET;
            dwell        <= 0;
            latch_model  <= '0;
            for (int i = 0; i < `ERR_CNT_LANES; i++) begin
                cnt_model[i] <= '0;
            end
        end else begin
            cmd_stage1  <= sent_cmd;
            cmd_stage2  <= cmd_stage1;
            resync_seen <= (cmd_stage2 == `CMD_RESYNC);
            if (&tx_reset_done) begin
                tx_done_seen <= 1'b1;
            end
            last_state <= state;
            dwell      <= (state != last_state) ? 1 : dwell + 1;
            latch_model <= cnt_reset_exp ? '0 : (latch_model | prbs_error);
            // Saturating count per upper lane
            for (int i = 0; i < `ERR_CNT_LANES; i++) begin
                if (cnt_clear) begin
                    cnt_model[i] <= '0;
                end else if (prbs_error[`ERR_CNT_FIRST_LANE + i] && (cnt_model[i] != 2'd3)) begin
                    cnt_model[i] <= cnt_model[i] + 2'd1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_tx_reset: assert property (@(posedge clk40) disable iff (PRBS_reset)
        tx_reset == tx_reset_exp)
        else report_mismatch("tx_reset_o", $sampled(tx_reset), $sampled(tx_reset_exp));
    a_rx_reset: assert property (@(posedge clk40) disable iff (PRBS_reset)
        rx_reset == rx_reset_exp)
        else report_mismatch("rx_reset_o", $sampled(rx_reset), $sampled(rx_reset_exp));
    // Receivers held until every transmitter reported done
    a_rx_held: assert property (@(posedge clk40) disable iff (PRBS_reset)
        !tx_done_seen |-> (rx_reset == 8'hff))
        else report_mismatch("rx_reset_o", $sampled(rx_reset), 8'hff);
    // Only a resync sends the state back to RESET
    a_order: assert property (@(posedge clk40) disable iff (PRBS_reset)
        (state != last_state) |->
            (((state == RESET) && resync_seen) ||
             (4'(state) == 4'(last_state) + 4'd1)))
        else report_failure("state_o left the boot order");
    a_dwell: assert property (@(posedge clk40) disable iff (PRBS_reset)
        ((state != last_state) && (state != RESET) && (dwell_expected != 0))
            |-> (dwell == dwell_expected))
        else report_mismatch("step length", 8'($sampled(dwell)), 8'($sampled(dwell_expected)));
    a_inject: assert property (@(posedge clk40) disable iff (PRBS_reset)
        error_inject == inject_exp)
        else report_mismatch("error_inject_o", 8'($sampled(error_inject)),
                             8'($sampled(inject_exp)));
    a_cnt_reset: assert property (@(posedge clk40) disable iff (PRBS_reset)
        prbs_cnt_reset == cnt_reset_exp)
        else report_mismatch("prbs_cnt_reset_o", 8'($sampled(prbs_cnt_reset)),
                             8'($sampled(cnt_reset_exp)));
    a_led: assert property (@(posedge clk40) disable iff (PRBS_reset)
        led == led_exp)
        else report_mismatch("led_o", $sampled(led), $sampled(led_exp));
    // Resync lands in RESET three edges after the command
    a_resync: assert property (@(posedge clk40) disable iff (PRBS_reset)
        resync_seen |-> (state == RESET))
        else report_mismatch("state_o", 8'($sampled(state)), 8'(RESET));

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] expected);
        $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, expected);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        stop_run();
    endtask

    task automatic wait_for_state(input boot_state_t target, input int limit);
        int waited;
        waited = 0;
        while ((state != target) && (waited < limit)) begin
            @(negedge clk40);
            waited++;
        end
        if (state != target) begin
            report_failure($sformatf("state %s not reached in %0d cycles",
                                     target.name(), limit));
        end
    endtask

    // One strobed command on the active-low bus
    task automatic send_command(input ccb_cmd_t code);
        @(negedge clk40);
        ccb_cmd_n    = ~code;
        ccb_strobe_n = 1'b0;
        sent_cmd     = code;
        @(negedge clk40);
        ccb_cmd_n    = '1;
        ccb_strobe_n = 1'b1;
        sent_cmd     = '0;
    endtask

    task automatic random_errors(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk40);
            prbs_error = ($urandom_range(0, 3) == 0) ? lane_vec_t'($urandom) : '0;
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        report_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        void'($urandom(32'hf189d43e));
        PRBS_reset    = 1'b1;
        ccb_cmd_n     = '1;
        ccb_strobe_n  = 1'b1;
        inject        = 1'b0;
        tx_reset_done = '0;
        rx_reset_done = '0;
        prbs_error    = '0;
        sent_cmd      = '0;
        repeat (RESET_CYCLES) @(posedge clk40);
        @(negedge clk40);
        PRBS_reset = 1'b0;

        // Done inputs stay low for a while in EN_TX_DONE
        wait_for_state(EN_TX_DONE, `TX_WAIT_CYCLES + 10);
        repeat (10) @(negedge clk40);
        tx_reset_done = '1;
        rx_reset_done = '1;

        // One error pulse per counted lane during injection
        wait_for_state(PRBS_INJECT, `RX_WAIT_CYCLES + 10);
        for (int lane = `ERR_CNT_FIRST_LANE; lane < `LANE_COUNT; lane++) begin
            @(negedge clk40);
            prbs_error = lane_vec_t'(1) << lane;
            @(negedge clk40);
            prbs_error = '0;
            repeat (2) @(negedge clk40);
        end
        wait_for_state(EN_PRBS_CK, `CLEAR_END_CYCLES + 10);

        // Random errors on the counters around a bxreset
        random_errors(RANDOM_CYCLES);
        send_command(`CMD_BXRESET);
        random_errors(RANDOM_CYCLES);
        prbs_error = '0;

        // Random inject pin followed by a bx0 with the pin low
        for (int i = 0; i < INJECT_CYCLES; i++) begin
            @(negedge clk40);
            inject = ($urandom_range(0, 1) == 1);
        end
        inject = 1'b0;
        send_command(`CMD_BX0);
        repeat (5) @(negedge clk40);

        // Resync restarts the boot
        send_command(`CMD_RESYNC);
        wait_for_state(RESET, 5);
        wait_for_state(EN_TX, 5);
        repeat (5) @(negedge clk40);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/link_test_top.sv
`default_nettype none

module link_test_top (
    input  wire                           clk40,
    input  wire                           PRBS_reset,
    input  wire link_test_pkg::ccb_cmd_t  ccb_cmd_n_i,
    input  wire                           ccb_strobe_n_i,
    input  wire                           inject_i,
    input  wire link_test_pkg::lane_vec_t tx_reset_done_i,
    input  wire link_test_pkg::lane_vec_t rx_reset_done_i,
    input  wire link_test_pkg::lane_vec_t prbs_error_i,
    output wire link_test_pkg::lane_vec_t tx_reset_o,
    output wire link_test_pkg::lane_vec_t rx_reset_o,
    output wire                           error_inject_o,
    output wire                           prbs_cnt_reset_o,
    output wire link_test_pkg::led_t      led_o,
    output wire link_test_pkg::boot_state_t state_o
);

    // Decoded CCB command pulses
    wire bx0;
    wire resync;
    wire bxreset;
    // Clear strobes from the sequencer to the monitor
    wire err_clear;
    wire latch_clear;

    ccb_cmd_decoder ccb_cmd_decoder_inst (
        .clk40          (clk40),
        .PRBS_reset     (PRBS_reset),
        .ccb_cmd_n_i    (ccb_cmd_n_i),
        .ccb_strobe_n_i (ccb_strobe_n_i),
        .bx0_o          (bx0),
        .resync_o       (resync),
        .bxreset_o      (bxreset)
    );

    link_boot_sequencer link_boot_sequencer_inst (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .bx0_i           (bx0),
        .resync_i        (resync),
        .bxreset_i       (bxreset),
        .inject_i        (inject_i),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .state_o         (state_o),
        .tx_reset_o      (tx_reset_o),
        .rx_reset_o      (rx_reset_o),
        .error_inject_o  (error_inject_o),
        .err_clear_o     (err_clear),
        .latch_clear_o   (latch_clear)
    );

    // Transceiver PRBS counters reset together with the latches
    assign prbs_cnt_reset_o = latch_clear;

    prbs_error_monitor prbs_error_monitor_inst (
        .clk40         (clk40),
        .PRBS_reset    (PRBS_reset),
        .prbs_error_i  (prbs_error_i),
        .state_i       (state_o),
        .err_clear_i   (err_clear),
        .latch_clear_i (latch_clear),
        .led_o         (led_o)
    );

endmodule

`default_nettype wire

//--- rtl/prbs_error_monitor.sv
`default_nettype none

`include "link_test_defines.svh"

module prbs_error_monitor (
    input  wire                             clk40,
    input  wire                             PRBS_reset,
    input  wire link_test_pkg::lane_vec_t   prbs_error_i,
    input  wire link_test_pkg::boot_state_t state_i,
    input  wire                             err_clear_i,
    input  wire                             latch_clear_i,
    output link_test_pkg::led_t             led_o
);

    import link_test_pkg::*;

    // Sticky error flag per lane
    lane_vec_t latch_q;
    // Saturating counts, index 0 is lane ERR_CNT_FIRST_LANE
    err_cnt_t  cnt_q [`ERR_CNT_LANES];

    //////////////////////////////////////////////////////////////////////
    // Error latches and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            latch_q <= '0;
        end else if (latch_clear_i) begin
            latch_q <= '0;
        end else begin
            latch_q <= latch_q | prbs_error_i;
        end
    end

    for (genvar g = 0; g < `ERR_CNT_LANES; g++) begin : g_err_cnt
        // Clear wins over a same-cycle error
        always_ff @(posedge clk40 or posedge PRBS_reset) begin
            if (PRBS_reset) begin
                cnt_q[g] <= '0;
            end else if (err_clear_i) begin
                cnt_q[g] <= '0;
            end else if (prbs_error_i[`ERR_CNT_FIRST_LANE + g] && (cnt_q[g] != '1)) begin
                cnt_q[g] <= cnt_q[g] + err_cnt_t'(1);
            end
        end

        // Count only holds, steps up by one, or drops on a clear
        a_cnt_step: assert property (@(posedge clk40) disable iff (PRBS_reset)
            !$past(err_clear_i) |->
                ((cnt_q[g] == $past(cnt_q[g])) ||
                 ({1'b0, cnt_q[g]} == {1'b0, $past(cnt_q[g])} + 3'd1)));
    end

    //////////////////////////////////////////////////////////////////////
    // Front-panel pattern
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        led_o = '0;
        case (state_i)
            RESET:             led_o = 8'h10;
            EN_TX:             led_o = 8'h20;
            EN_TX_DONE:        led_o = 8'h30;
            EN_RX:             led_o = 8'h40;
            EN_RX_DONE:        led_o = 8'h50;
            // Lower nibble shows lanes 7 to 4
            PRBS_INJECT:       led_o = {4'h6, latch_q[7:4]};
            PRBS_INJECT_DONE:  led_o = {4'h8, latch_q[7:4]};
            PRBS_INJECT_CLEAR: led_o = {4'h7, latch_q[7:4]};
            // One LED pair per counter, lane 4 on top
            EN_PRBS_CK: begin
                for (int i = 0; i < `ERR_CNT_LANES; i++) begin
                    led_o[7 - 2*i -: 2] = cnt_q[i];
                end
            end
            default:           led_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/link_boot_sequencer.sv
`default_nettype none

`include "link_test_defines.svh"

module link_boot_sequencer (
    input  wire                           clk40,
    input  wire                           PRBS_reset,
    input  wire                           bx0_i,
    input  wire                           resync_i,
    input  wire                           bxreset_i,
    input  wire                           inject_i,
    input  wire link_test_pkg::lane_vec_t tx_reset_done_i,
    input  wire link_test_pkg::lane_vec_t rx_reset_done_i,
    output link_test_pkg::boot_state_t    state_o,
    output link_test_pkg::lane_vec_t      tx_reset_o,
    output link_test_pkg::lane_vec_t      rx_reset_o,
    output logic                          error_inject_o,
    output logic                          err_clear_o,
    output logic                          latch_clear_o
);

    import link_test_pkg::*;

    boot_state_t state_q;
    boot_state_t state_d;
    boot_cnt_t   cnt_q;
    // Counter runs in the timed steps only
    logic        cnt_run;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET: begin
                state_d = EN_TX;
            end
            EN_TX: begin
                if (cnt_q >= boot_cnt_t'(`TX_WAIT_CYCLES)) begin
                    state_d = EN_TX_DONE;
                end
            end
            // Wait for every transmitter to report done
            EN_TX_DONE: begin
                if (&tx_reset_done_i) begin
                    state_d = EN_RX;
                end
            end
            EN_RX: begin
                if (cnt_q >= boot_cnt_t'(`RX_WAIT_CYCLES)) begin
                    state_d = EN_RX_DONE;
                end
            end
            EN_RX_DONE: begin
                if (&rx_reset_done_i) begin
                    state_d = PRBS_INJECT;
                end
            end
            // Injection thresholds count on from zero across three steps
            PRBS_INJECT: begin
                if (cnt_q >= boot_cnt_t'(`INJECT_END_CYCLES)) begin
                    state_d = PRBS_INJECT_DONE;
                end
            end
            PRBS_INJECT_DONE: begin
                if (cnt_q >= boot_cnt_t'(`RESET_END_CYCLES)) begin
                    state_d = PRBS_INJECT_CLEAR;
                end
            end
            PRBS_INJECT_CLEAR: begin
                if (cnt_q >= boot_cnt_t'(`CLEAR_END_CYCLES)) begin
                    state_d = EN_PRBS_CK;
                end
            end
            // Checking is terminal until a resync
            EN_PRBS_CK: begin
                state_d = EN_PRBS_CK;
            end
            default: begin
                state_d = RESET;
            end
        endcase
        // Resync restarts the whole boot from any state
        if (resync_i) begin
            state_d = RESET;
        end
    end

    assign cnt_run = (state_q inside {EN_TX, EN_RX, PRBS_INJECT,
                                      PRBS_INJECT_DONE, PRBS_INJECT_CLEAR});

    // State register and step counter
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            state_q <= RESET;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_run ? cnt_q + boot_cnt_t'(1) : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control outputs
    //////////////////////////////////////////////////////////////////////

    assign state_o    = state_q;
    assign tx_reset_o = (state_q == RESET) ? '1 : '0;
    // Receivers stay in reset until the transmitter step is through
    assign rx_reset_o = (state_q inside {RESET, EN_TX, EN_TX_DONE}) ? '1 : '0;

    always_comb begin
        error_inject_o = 1'b0;
        err_clear_o    = 1'b1;
        latch_clear_o  = 1'b0;
        case (state_q)
            EN_RX_DONE, PRBS_INJECT: begin
                error_inject_o = 1'b1;
            end
            // Clear the latches and PRBS counters at the end of injection
            PRBS_INJECT_DONE: begin
                error_inject_o = 1'b1;
                latch_clear_o  = 1'b1;
            end
            // Live check, commands and the inject pin take over
            EN_PRBS_CK: begin
                error_inject_o = inject_i | bx0_i;
                err_clear_o    = bxreset_i;
                latch_clear_o  = bxreset_i;
            end
            default: begin
                error_inject_o = 1'b0;
            end
        endcase
    end

    a_tx_reset_whole: assert property (@(posedge clk40) disable iff (PRBS_reset)
        (tx_reset_o == '0) || (tx_reset_o == '1));
    a_rx_reset_whole: assert property (@(posedge clk40) disable iff (PRBS_reset)
        (rx_reset_o == '0) || (rx_reset_o == '1));

    // Receivers come out of reset only after all transmitters were done
    a_rx_after_tx: assert property (@(posedge clk40) disable iff (PRBS_reset)
        $fell(rx_reset_o[0]) |-> ($past(&tx_reset_done_i) && !tx_reset_o[0]));

endmodule

`default_nettype wire

//--- rtl/ccb_cmd_decoder.sv
`default_nettype none

`include "link_test_defines.svh"

module ccb_cmd_decoder (
    input  wire                      clk40,
    input  wire                      PRBS_reset,
    input  wire link_test_pkg::ccb_cmd_t ccb_cmd_n_i,
    input  wire                      ccb_strobe_n_i,
    output logic                     bx0_o,
    output logic                     resync_o,
    output logic                     bxreset_o
);

    import link_test_pkg::*;

    // First stage, inverted copy of the CCB pins
    ccb_cmd_t cmd_q;
    logic     strobe_q;

    // Input register
    // Bus idles high, so reset loads the idle (inverted) value
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            cmd_q    <= '0;
            strobe_q <= 1'b0;
        end else begin
            cmd_q    <= ~ccb_cmd_n_i;
            strobe_q <= ~ccb_strobe_n_i;
        end
    end

    // Second stage, registered command pulses
    // Only a valid strobe qualifies a compare
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            bx0_o     <= 1'b0;
            resync_o  <= 1'b0;
            bxreset_o <= 1'b0;
        end else begin
            bx0_o     <= strobe_q && (cmd_q == `CMD_BX0);
            resync_o  <= strobe_q && (cmd_q == `CMD_RESYNC);
            bxreset_o <= strobe_q && (cmd_q == `CMD_BXRESET);
        end
    end

    // Downstream logic expects at most one command per cycle
    a_single_cmd: assert property (@(posedge clk40) disable iff (PRBS_reset)
        $onehot0({bx0_o, resync_o, bxreset_o}));

endmodule

`default_nettype wire

//--- rtl/link_test_pkg.sv
`default_nettype none

package link_test_pkg;

    `include "link_test_defines.svh"

    // One bit per fiber lane
    typedef logic [`LANE_COUNT-1:0] lane_vec_t;
    // CCB command field
    typedef logic [5:0] ccb_cmd_t;
    // Boot step counter, wide enough for the last threshold
    typedef logic [7:0] boot_cnt_t;
    // Saturating per-lane error count
    typedef logic [1:0] err_cnt_t;
    // Front-panel LED bank
    typedef logic [7:0] led_t;

    // Boot sequencer states, codes 0 to 8 in boot order
    typedef enum logic [3:0] {
        RESET             = 4'd0,
        EN_TX             = 4'd1,
        EN_TX_DONE        = 4'd2,
        EN_RX             = 4'd3,
        EN_RX_DONE        = 4'd4,
        PRBS_INJECT       = 4'd5,
        PRBS_INJECT_DONE  = 4'd6,
        PRBS_INJECT_CLEAR = 4'd7,
        EN_PRBS_CK        = 4'd8
    } boot_state_t;

endpackage

`default_nettype wire

//--- include/link_test_defines.svh
`ifndef LINK_TEST_DEFINES_SVH
`define LINK_TEST_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Lane layout of the fiber board
//////////////////////////////////////////////////////////////////////

// Eight fiber lanes in total
`define LANE_COUNT          8
// Error counters sit on the upper four lanes only
`define ERR_CNT_FIRST_LANE  4
`define ERR_CNT_LANES       4

// CCB command codes, already inverted to active high
`define CMD_BX0             6'h01
`define CMD_RESYNC          6'h03
`define CMD_BXRESET         6'h32

//////////////////////////////////////////////////////////////////////
// Boot step thresholds, in clk40 cycles
//////////////////////////////////////////////////////////////////////

`define TX_WAIT_CYCLES      20
`define RX_WAIT_CYCLES      40
// Cumulative across the three injection steps
`define INJECT_END_CYCLES   140
`define RESET_END_CYCLES    160
`define CLEAR_END_CYCLES    180

`endif
